// File: hdl/id_pkg.sv
// widths, payload types, alu op enum, opcode and funct constants, nop encoding
package id_pkg;

  localparam int PC_WD       = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int GPR_WD      = 64;
  localparam int IMM_WD      = 64;

  localparam int GPR_COUNT   = 32;

  typedef logic [PC_WD-1:0]       pc_t;
  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [GPR_WD-1:0]      gpr_data_t;
  typedef logic [IMM_WD-1:0]      imm_t;
  typedef logic [2:0]             br_func_t;   // branch funct3
  typedef logic [2:0]             mem_op_t;    // load/store funct3, size and sign

  // pass hands the link or operand through, execute picks the source
  typedef enum logic [1:0] {
    ALU_ADD  = 2'd0,
    ALU_SUB  = 2'd1,
    ALU_PASS = 2'd2
  } alu_op_e;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // funct3 values
  localparam logic [2:0] F3_ADD     = 3'b000;  // addi, add, sub
  localparam logic [2:0] F3_JALR    = 3'b000;
  localparam logic [2:0] F3_DWORD   = 3'b011;  // ld / sd
  localparam br_func_t   BR_BEQ     = 3'b000;
  localparam br_func_t   BR_BNE     = 3'b001;
  localparam br_func_t   BR_BLT     = 3'b100;

  // funct7 values for the register-register ops
  localparam logic [6:0] F7_ADD     = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // addi x0, x0, 0
  localparam inst_t      NOP_INST   = 32'h0000_0013;

endpackage

// File: hdl/id_decoder.sv
// combinational decoder for addi, add, sub, ld, sd, beq, bne, blt, jal, jalr
`timescale 1ns/1ps
module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::imm_t      o_imm,
  output id_pkg::alu_op_e   o_alu_op,
  output logic              o_alu_src2_imm,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output id_pkg::mem_op_t   o_mem_op,
  output logic              o_load_sel,
  output logic              o_bren,
  output id_pkg::br_func_t  o_br_func,
  output logic              o_jal,
  output logic              o_jalr,
  output logic              o_invalid_inst
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_t       imm_i;
  imm_t       imm_s;
  imm_t       imm_b;
  imm_t       imm_j;
  logic       use_rs1;
  logic       use_rs2;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm          = '0;
    o_alu_op       = ALU_ADD;
    o_alu_src2_imm = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_mem_op       = '0;
    o_load_sel     = 1'b0;
    o_bren         = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_invalid_inst = 1'b0;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD) begin
          o_imm          = imm_i;
          o_alu_src2_imm = 1'b1;
          o_gpr_wen      = 1'b1;
          use_rs1        = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD && (funct7 == F7_ADD || funct7 == F7_SUB)) begin
          o_alu_op  = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          o_gpr_wen = 1'b1;
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == F3_DWORD) begin
          o_imm          = imm_i;
          o_alu_src2_imm = 1'b1;   // address = rs1 + imm
          o_gpr_wen      = 1'b1;
          o_mem_ren      = 1'b1;
          o_mem_op       = funct3;
          o_load_sel     = 1'b1;
          use_rs1        = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_DWORD) begin
          o_imm          = imm_s;
          o_alu_src2_imm = 1'b1;
          o_mem_wen      = 1'b1;
          o_mem_op       = funct3;
          use_rs1        = 1'b1;
          use_rs2        = 1'b1;   // store data
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == BR_BEQ || funct3 == BR_BNE || funct3 == BR_BLT) begin
          o_imm    = imm_b;
          o_alu_op = ALU_PASS;
          o_bren   = 1'b1;
          use_rs1  = 1'b1;
          use_rs2  = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_JAL: begin
        o_imm     = imm_j;
        o_alu_op  = ALU_PASS;   // link pc+4 formed in execute
        o_gpr_wen = 1'b1;
        o_jal     = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == F3_JALR) begin
          o_imm     = imm_i;
          o_alu_op  = ALU_PASS;
          o_gpr_wen = 1'b1;
          o_jalr    = 1'b1;
          use_rs1   = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      default: o_invalid_inst = 1'b1;
    endcase
  end

  // unused fields read as x0, keeps the stall check honest
  assign o_rs1     = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2     = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd      = o_gpr_wen ? i_inst[11:7] : '0;
  assign o_br_func = funct3;

  always_comb begin
    a_mem_onehot: assert ($onehot0({o_mem_ren, o_mem_wen}))
      else $error("decoder raised both memory enables");
  end

endmodule

// File: hdl/id_gpr_file.sv
// 32 x 64 register file, two read ports, one write port, x0 hard zero
`timescale 1ns/1ps
module id_gpr_file (
  input  logic              i_clk,
  input  logic              i_rst,
  // read ports
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::gpr_data_t o_rdata1,
  output id_pkg::gpr_data_t o_rdata2,
  // write port from write back
  input  logic              i_wen,
  input  id_pkg::gpr_addr_t i_waddr,
  input  id_pkg::gpr_data_t i_wdata
);
  import id_pkg::*;

  gpr_data_t regs [GPR_COUNT];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < GPR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin   // x0 never written
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write-through, same cycle results come over the bypass
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

endmodule

// File: hdl/id_hazard_unit.sv
// operand forwarding from execute and memory, load-use stall detection
`timescale 1ns/1ps
module id_hazard_unit (
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  id_pkg::gpr_data_t i_rf_data1,
  input  id_pkg::gpr_data_t i_rf_data2,
  // execute bypass
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_data_t i_es_result,
  input  logic              i_es_load_sel,
  // memory bypass
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_data_t i_ms_result,
  output id_pkg::gpr_data_t o_rs1_data,
  output id_pkg::gpr_data_t o_rs2_data,
  output logic              o_load_stall
);
  import id_pkg::*;

  logic es_hit1;
  logic es_hit2;
  logic ms_hit1;
  logic ms_hit2;

  // x0 is never a forwarding source
  function automatic logic hit(input gpr_addr_t rd, input gpr_addr_t rs);
    return (rd != '0) && (rd == rs);
  endfunction

  // youngest producer wins
  function automatic gpr_data_t pick(input logic es_hit, input logic ms_hit,
                                     input gpr_data_t es_data, input gpr_data_t ms_data,
                                     input gpr_data_t rf_data);
    if (es_hit) begin
      return es_data;
    end else if (ms_hit) begin
      return ms_data;
    end
    return rf_data;
  endfunction

  assign es_hit1 = hit(i_es_rd, i_rs1);
  assign es_hit2 = hit(i_es_rd, i_rs2);
  assign ms_hit1 = hit(i_ms_rd, i_rs1);
  assign ms_hit2 = hit(i_ms_rd, i_rs2);

  assign o_rs1_data = pick(es_hit1, ms_hit1, i_es_result, i_ms_result, i_rf_data1);
  assign o_rs2_data = pick(es_hit2, ms_hit2, i_es_result, i_ms_result, i_rf_data2);

  // load data only exists once the load reaches memory
  assign o_load_stall = i_es_load_sel && (es_hit1 || es_hit2);

endmodule

// File: hdl/id_branch_unit.sv
// branch condition evaluation and jump target computation
`timescale 1ns/1ps
module id_branch_unit (
  input  id_pkg::pc_t       i_pc,
  input  id_pkg::imm_t      i_imm,
  input  id_pkg::gpr_data_t i_rs1_data,
  input  id_pkg::gpr_data_t i_rs2_data,
  input  logic              i_bren,
  input  id_pkg::br_func_t  i_br_func,
  input  logic              i_jal,
  input  logic              i_jalr,
  output logic              o_br_sel,
  output id_pkg::pc_t       o_br_target
);
  import id_pkg::*;

  logic cond;
  pc_t  pc_rel;
  pc_t  reg_rel;

  always_comb begin
    case (i_br_func)
      BR_BEQ:  cond = (i_rs1_data == i_rs2_data);
      BR_BNE:  cond = (i_rs1_data != i_rs2_data);
      BR_BLT:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      default: cond = 1'b0;
    endcase
  end

  assign pc_rel  = i_pc + i_imm;
  assign reg_rel = i_rs1_data + i_imm;

  assign o_br_sel    = i_jal || i_jalr || (i_bren && cond);
  assign o_br_target = i_jalr ? {reg_rel[63:1], 1'b0} : pc_rel;   // jalr clears bit 0

  always_comb begin
    a_sel_kind: assert (!o_br_sel || i_bren || i_jal || i_jalr)
      else $error("redirect selected without a branch or jump");
  end

endmodule

// File: hdl/id_stage.sv
// decode stage top: pipeline register, valid/allowin, squash, redirect, submodules
`timescale 1ns/1ps
module id_stage (
  input  logic              i_clk,
  input  logic              i_rst,
  // from fetch
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::pc_t       i_fs_pc,
  output logic              o_ds_allowin,
  // to execute
  input  logic              i_es_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::gpr_data_t o_rs1_data,
  output id_pkg::gpr_data_t o_rs2_data,
  output id_pkg::imm_t      o_imm,
  output id_pkg::pc_t       o_pc,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::alu_op_e   o_alu_op,
  output logic              o_alu_src2_imm,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output id_pkg::mem_op_t   o_mem_op,
  output logic              o_load_sel,
  output logic              o_invalid_inst,
  // redirect to fetch
  output logic              o_br_taken,
  output id_pkg::pc_t       o_br_target,
  // write back
  input  logic              i_wb_wen,
  input  id_pkg::gpr_addr_t i_wb_addr,
  input  id_pkg::gpr_data_t i_wb_data,
  // bypass
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_data_t i_es_result,
  input  logic              i_es_load_sel,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_data_t i_ms_result
);
  import id_pkg::*;

  logic      ds_valid;
  logic      ds_ready_go;
  inst_t     ds_inst;
  pc_t       ds_pc;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  gpr_data_t rf_rdata1;
  gpr_data_t rf_rdata2;
  logic      bren;
  br_func_t  br_func;
  logic      jal;
  logic      jalr;
  logic      br_sel;
  logic      load_stall;

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_pc             = ds_pc;

  // resolve only with final operands, skip if fetch already sits on the target
  assign o_br_taken = ds_valid && ds_ready_go && br_sel && (o_br_target != i_fs_pc);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_inst <= NOP_INST;
      ds_pc   <= '0;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= o_br_taken ? NOP_INST : i_fs_inst;   // wrong-path slot becomes a nop
      ds_pc   <= i_fs_pc;
    end
  end

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src2_imm (o_alu_src2_imm),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_load_sel     (o_load_sel),
    .o_bren         (bren),
    .o_br_func      (br_func),
    .o_jal          (jal),
    .o_jalr         (jalr),
    .o_invalid_inst (o_invalid_inst)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_addr),
    .i_wdata  (i_wb_data)
  );

  id_hazard_unit u_hazard_unit (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_data1    (rf_rdata1),
    .i_rf_data2    (rf_rdata2),
    .i_es_rd       (i_es_rd),
    .i_es_result   (i_es_result),
    .i_es_load_sel (i_es_load_sel),
    .i_ms_rd       (i_ms_rd),
    .i_ms_result   (i_ms_result),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_branch_unit (
    .i_pc        (ds_pc),
    .i_imm       (o_imm),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_bren      (bren),
    .i_br_func   (br_func),
    .i_jal       (jal),
    .i_jalr      (jalr),
    .o_br_sel    (br_sel),
    .o_br_target (o_br_target)
  );

  a_no_issue_in_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    load_stall |-> !o_ds_to_es_valid);

  a_redirect_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_br_taken |-> ds_valid);

endmodule

// File: sim/tb_clock.sv
// free-running testbench clock, 10 ns period
`timescale 1ns/1ps
module tb_clock (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #5 o_clk = ~o_clk;   // half period
    end
  end

endmodule

// File: sim/id_stage_tb.sv
// decode stage testbench: trace reader, issue and write-back tasks, typed compare tasks
`timescale 1ns/1ps
module id_stage_tb;
  import id_pkg::*;

  logic      clk;
  logic      rst;
  logic      fs_to_ds_valid;
  inst_t     fs_inst;
  pc_t       fs_pc;
  logic      es_allowin;
  logic      wb_wen;
  gpr_addr_t wb_addr;
  gpr_data_t wb_data;
  gpr_addr_t es_rd;
  gpr_data_t es_result;
  logic      es_load_sel;
  gpr_addr_t ms_rd;
  gpr_data_t ms_result;

  logic      ds_allowin;
  logic      ds_to_es_valid;
  gpr_data_t rs1_data;
  gpr_data_t rs2_data;
  imm_t      imm;
  pc_t       pc;
  gpr_addr_t rd;
  alu_op_e   alu_op;
  logic      alu_src2_imm;
  logic      gpr_wen;
  logic      mem_ren;
  logic      mem_wen;
  mem_op_t   mem_op;
  logic      load_sel;
  logic      invalid_inst;
  logic      br_taken;
  pc_t       br_target;

  // fields of the current trace line
  gpr_addr_t t_wb_addr;
  gpr_data_t t_wb_data;
  pc_t       t_pc;
  inst_t     t_inst;
  pc_t       t_fpc;
  gpr_addr_t t_es_rd;
  gpr_data_t t_es_res;
  logic      t_es_load;
  gpr_addr_t t_ms_rd;
  gpr_data_t t_ms_res;
  gpr_data_t t_exp_rs1;
  gpr_data_t t_exp_rs2;
  imm_t      t_exp_imm;
  gpr_addr_t t_exp_rd;
  logic [1:0] t_exp_alu;
  logic [7:0] t_exp_ctl;   // mem_op, src2_imm, gpr_wen, mem_ren, mem_wen, load_sel
  logic      t_exp_inv;
  logic      t_exp_brt;
  pc_t       t_exp_tgt;

  tb_clock u_clock (.o_clk(clk));

  id_stage i_id_stage (
    .i_clk (clk), .i_rst (rst),
    .i_fs_to_ds_valid (fs_to_ds_valid), .i_fs_inst (fs_inst), .i_fs_pc (fs_pc),
    .o_ds_allowin (ds_allowin), .i_es_allowin (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid), .o_rs1_data (rs1_data), .o_rs2_data (rs2_data),
    .o_imm (imm), .o_pc (pc), .o_rd (rd), .o_alu_op (alu_op),
    .o_alu_src2_imm (alu_src2_imm), .o_gpr_wen (gpr_wen), .o_mem_ren (mem_ren),
    .o_mem_wen (mem_wen), .o_mem_op (mem_op), .o_load_sel (load_sel),
    .o_invalid_inst (invalid_inst), .o_br_taken (br_taken), .o_br_target (br_target),
    .i_wb_wen (wb_wen), .i_wb_addr (wb_addr), .i_wb_data (wb_data),
    .i_es_rd (es_rd), .i_es_result (es_result), .i_es_load_sel (es_load_sel),
    .i_ms_rd (ms_rd), .i_ms_result (ms_result)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input gpr_data_t got, input gpr_data_t exp);
    if (got !== exp) abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input gpr_addr_t got, input gpr_addr_t exp);
    if (got !== exp) abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_alu(input string name, input alu_op_e got, input alu_op_e exp);
    if (got !== exp) abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_mem_op(input string name, input mem_op_t got, input mem_op_t exp);
    if (got !== exp) abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  // all waits sample at the falling edge
  task automatic wait_allowin(input int max_cycles);
    int n;
    n = 0;
    while (ds_allowin !== 1'b1) begin
      if (n == max_cycles) abort_run("timeout: o_ds_allowin never went high");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_valid(input int max_cycles);
    int n;
    n = 0;
    while (ds_to_es_valid !== 1'b1) begin
      if (n == max_cycles) abort_run("timeout: o_ds_to_es_valid never went high");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic write_back();
    @(posedge clk);
    wb_wen  <= 1'b1;
    wb_addr <= t_wb_addr;
    wb_data <= t_wb_data;
    @(posedge clk);
    wb_wen  <= 1'b0;   // write landed at this edge
  endtask

  task automatic check_outputs();
    check_bit("o_ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_bit("o_ds_allowin", ds_allowin, 1'b0);   // execute holds it
    check_data("o_rs1_data", rs1_data, t_exp_rs1);
    check_data("o_rs2_data", rs2_data, t_exp_rs2);
    check_data("o_imm", imm, t_exp_imm);
    check_pc("o_pc", pc, t_pc);
    check_addr("o_rd", rd, t_exp_rd);
    check_alu("o_alu_op", alu_op, alu_op_e'(t_exp_alu));
    check_mem_op("o_mem_op", mem_op, t_exp_ctl[7:5]);
    check_bit("o_alu_src2_imm", alu_src2_imm, t_exp_ctl[4]);
    check_bit("o_gpr_wen", gpr_wen, t_exp_ctl[3]);
    check_bit("o_mem_ren", mem_ren, t_exp_ctl[2]);
    check_bit("o_mem_wen", mem_wen, t_exp_ctl[1]);
    check_bit("o_load_sel", load_sel, t_exp_ctl[0]);
    check_bit("o_invalid_inst", invalid_inst, t_exp_inv);
    check_bit("o_br_taken", br_taken, t_exp_brt);
    if (t_exp_brt) check_pc("o_br_target", br_target, t_exp_tgt);
  endtask

  // offer while the previous instruction leaves, so its redirect sees this pc
  task automatic run_issue();
    int hold;
    @(posedge clk);
    es_allowin     <= 1'b1;
    fs_to_ds_valid <= 1'b1;
    fs_inst        <= t_inst;
    fs_pc          <= t_pc;
    @(negedge clk);
    wait_allowin(20);
    @(posedge clk);   // capture edge
    es_allowin     <= 1'b0;
    fs_to_ds_valid <= 1'b0;
    fs_pc          <= t_fpc;
    es_rd          <= t_es_rd;
    es_result      <= t_es_res;
    es_load_sel    <= t_es_load;
    ms_rd          <= t_ms_rd;
    ms_result      <= t_ms_res;
    @(negedge clk);
    if (t_es_load) begin
      check_bit("o_ds_to_es_valid", ds_to_es_valid, 1'b0);   // load-use stall
      @(posedge clk);
      es_load_sel <= 1'b0;
      @(negedge clk);
    end
    wait_valid(20);
    check_outputs();
    hold = $urandom % 4;
    repeat (hold) begin
      @(negedge clk);
      check_outputs();   // nothing may move under back-pressure
    end
  endtask

  initial begin
    int    fd;
    int    r;
    int    n;
    int    seed_draw;
    string line;
    byte   kind;
    rst            <= 1'b1;
    fs_to_ds_valid <= 1'b0;
    fs_inst        <= NOP_INST;
    fs_pc          <= '0;
    es_allowin     <= 1'b0;
    wb_wen         <= 1'b0;
    wb_addr        <= '0;
    wb_data        <= '0;
    es_rd          <= '0;
    es_result      <= '0;
    es_load_sel    <= 1'b0;
    ms_rd          <= '0;
    ms_result      <= '0;
    seed_draw = $urandom(32'hccc7);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    fd = $fopen("sim/id_trace.txt", "r");
    if (fd == 0) abort_run("could not open the trace file sim/id_trace.txt");
    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      if (r != 0 && line.len() > 1 && line.getc(0) != "#") begin
        kind = line.getc(0);
        if (kind == "w") begin
          n = $sscanf(line, "w %h %h", t_wb_addr, t_wb_data);
          if (n != 2) abort_run($sformatf("malformed write-back line in trace: %s", line));
          write_back();
        end else if (kind == "i") begin
          n = $sscanf(line, "i %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      t_pc, t_inst, t_fpc, t_es_rd, t_es_res, t_es_load, t_ms_rd, t_ms_res,
                      t_exp_rs1, t_exp_rs2, t_exp_imm, t_exp_rd, t_exp_alu, t_exp_ctl,
                      t_exp_inv, t_exp_brt, t_exp_tgt);
          if (n != 17) abort_run($sformatf("malformed issue line in trace: %s", line));
          run_issue();
        end else begin
          abort_run($sformatf("unknown line kind in trace: %s", line));
        end
      end
    end
    $fclose(fd);
    // let the last instruction leave, stage must go empty
    @(posedge clk);
    es_allowin <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_bit("o_ds_to_es_valid", ds_to_es_valid, 1'b0);
    check_bit("o_br_taken", br_taken, 1'b0);
    check_bit("o_ds_allowin", ds_allowin, 1'b1);
    $display("sim passed");
    $finish;
  end

endmodule

// File: sim/id_trace.txt
# w: addr data (write-back)
# i: pc inst fetch_pc es_rd es_res es_load ms_rd ms_res rs1 rs2 imm rd alu ctl inv br_taken target
# ctl = {mem_op[2:0], src2_imm, gpr_wen, mem_ren, mem_wen, load_sel}, es_load 1 means stall
w 1 5
w 2 fffffffffffffffd
w 3 1000
w 5 5
w 0 deadbeef
i 1000 00708213 1004 0 0 0 0 0 5 0 7 4 0 18 0 0 0
i 1004 00208333 1008 0 0 0 0 0 5 fffffffffffffffd 0 6 0 08 0 0 0
i 1008 401003b3 100c 0 0 0 0 0 0 5 0 7 1 08 0 0 0
i 100c 00208433 1010 1 111 0 2 222 111 222 0 8 0 08 0 0 0
i 1010 00208433 1014 1 aaa 0 1 bbb aaa fffffffffffffffd 0 8 0 08 0 0 0
i 1014 00200433 1018 0 999 0 0 888 0 fffffffffffffffd 0 8 0 08 0 0 0
i 1018 0101b483 101c 0 0 0 0 0 1000 0 10 9 0 7d 0 0 0
i 101c 00148533 1020 9 4444 1 0 0 4444 5 0 a 0 08 0 0 0
i 1020 0021b423 1024 0 0 0 0 0 1000 fffffffffffffffd 8 0 0 72 0 0 0
i 1024 00508863 1028 0 0 0 0 0 5 5 10 0 2 00 0 1 1034
i 1028 00208333 102c 0 0 0 0 0 0 0 0 0 0 18 0 0 0
i 1034 00509863 1038 0 0 0 0 0 5 5 10 0 2 00 0 0 0
i 1038 fe114ce3 103c 0 0 0 0 0 fffffffffffffffd 5 fffffffffffffff8 0 2 00 0 1 1030
i 1030 008005ef 1038 0 0 0 0 0 0 0 8 b 2 08 0 0 0
i 1038 00518667 103c 0 0 0 3 2000 2000 0 5 c 2 08 0 1 2004
i 103c 00708213 1040 0 0 0 0 0 0 0 0 0 0 18 0 0 0
i 1040 0000007f 1044 0 0 0 0 0 0 0 0 0 0 00 1 0 0
i 1044 00109093 1048 0 0 0 0 0 0 0 0 0 0 00 1 0 0

// File: id_stage.f
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_gpr_file.sv
hdl/id_hazard_unit.sv
hdl/id_branch_unit.sv
hdl/id_stage.sv
sim/tb_clock.sv
sim/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb -o id_stage_sim \
  && ./obj_dir/id_stage_sim > sim.log 2>&1
grep -q "sim passed" sim.log && echo "run ok" || { echo "run failed, see sim.log"; exit 1; }
